// File: Bender.yml
package:
  name: cpu_axi_bridge

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/axi_bridge_pkg.sv
      - src/access_sequencer.sv
      - src/fetch_master.sv
      - src/data_master.sv
      - src/cpu_axi_bridge.sv
      - target: simulation
        include_dirs:
          - common
        files:
          - verification/bridge_checker.sv
          - verification/tb_cpu_axi_bridge.sv

// File: common/axi_bridge_macros.svh
`ifndef AXI_BRIDGE_MACROS_SVH
`define AXI_BRIDGE_MACROS_SVH

// ==================================================
// Bus widths
// ==================================================

// Byte address on both masters
`define AXI_ADDR_BITS 32

// One instruction or data word per beat
`define AXI_DATA_BITS 32

// ==================================================
// FSM encoding
// ==================================================

// Wide enough for the four-state machines
`define BRIDGE_STATE_BITS 2

// ==================================================
// Simulation limits
// ==================================================

// Worst case per step, store plus fetch with slow slave
`define TB_STEP_SLACK 64

`endif

// File: common/axi_bridge_pkg.sv
`include "axi_bridge_macros.svh"

package axi_bridge_pkg;

	// ==================================================
	// Plain vectors
	// ==================================================

	typedef logic [`AXI_ADDR_BITS-1:0] addr_t;	// Byte address
	typedef logic [`AXI_DATA_BITS-1:0] word_t;	// Instruction or data

	// Data side operation of one step
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_op_e;

	// ==================================================
	// Channel bundles
	// ==================================================

	// One processor step, held while stall is high
	typedef struct packed {
		addr_t   fetch_addr;
		mem_op_e op;
		addr_t   data_addr;
		word_t   store_data;
	} cpu_step_t;

	// AR or AW as driven by a master
	typedef struct packed {
		logic  valid;
		addr_t addr;
	} axi_addr_req_t;

	// R as driven by the slave
	typedef struct packed {
		logic  valid;
		word_t data;
		logic  last;
	} axi_r_rsp_t;

	// W, always a single full-word beat
	typedef struct packed {
		logic  valid;
		word_t data;
		logic  last;
	} axi_w_req_t;

	// ==================================================
	// FSM states
	// ==================================================

	typedef enum logic [`BRIDGE_STATE_BITS-1:0] {
		SEQ_IDLE, SEQ_DATA, SEQ_FETCH, SEQ_DONE
	} seq_state_e;

	typedef enum logic [`BRIDGE_STATE_BITS-1:0] {
		RD_IDLE, RD_ADDR, RD_DATA
	} rd_state_e;

	typedef enum logic [`BRIDGE_STATE_BITS-1:0] {
		WR_IDLE, WR_ADDR, WR_DATA, WR_RESP
	} wr_state_e;

endpackage

// File: flist.f
+incdir+common
common/axi_bridge_pkg.sv
src/access_sequencer.sv
src/fetch_master.sv
src/data_master.sv
src/cpu_axi_bridge.sv
verification/bridge_checker.sv
verification/tb_cpu_axi_bridge.sv

// File: src/access_sequencer.sv
`timescale 1ns/100ps

module access_sequencer
	import axi_bridge_pkg::*;
(
	input  logic    ACLK,
	input  logic    ARESETn,
	input  mem_op_e op,
	output logic    fetch_start,
	input  logic    fetch_done,
	output logic    data_start,
	input  logic    data_done,
	output logic    stall
);

	seq_state_e state;
	seq_state_e state_nxt;
	logic       has_data;

	assign has_data = (op != MEM_NONE);	// Load or store in this step

	// ==================================================
	// Step ordering
	// ==================================================

	always_comb begin
		state_nxt = state;
		case (state)
			SEQ_IDLE: begin
				// Data phase goes first when there is one
				if (has_data) begin
					state_nxt = SEQ_DATA;
				end else begin
					state_nxt = SEQ_FETCH;
				end
			end
			SEQ_DATA: begin
				if (data_done) begin
					state_nxt = SEQ_FETCH;
				end
			end
			SEQ_FETCH: begin
				if (fetch_done) begin
					state_nxt = SEQ_DONE;
				end
			end
			SEQ_DONE: begin
				state_nxt = SEQ_IDLE;	// Single release cycle
			end
			default: begin
				state_nxt = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state       <= SEQ_IDLE;
			stall       <= 1'b1;
			data_start  <= 1'b0;
			fetch_start <= 1'b0;
		end else begin
			state <= state_nxt;
			// Low only while sitting in SEQ_DONE
			stall <= (state_nxt != SEQ_DONE);

			data_start  <= (state == SEQ_IDLE) && has_data;
			fetch_start <= ((state == SEQ_IDLE) && !has_data) ||
				((state == SEQ_DATA) && data_done);
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	// Only one master may be kicked at a time
	a_single_start: assert property (
		@(posedge ACLK) disable iff (!ARESETn)
		!(fetch_start && data_start)
	) else $error("fetch_start and data_start high together");

endmodule

// File: src/cpu_axi_bridge.sv
`timescale 1ns/100ps

module cpu_axi_bridge
	import axi_bridge_pkg::*;
(
	input  logic          ACLK,
	input  logic          ARESETn,
	// Processor side
	input  cpu_step_t     step,
	output logic          stall,
	output word_t         instr,
	output word_t         load_data,
	// M0, instruction fetch
	output axi_addr_req_t ar_m0,
	input  logic          arready_m0,
	input  axi_r_rsp_t    r_m0,
	output logic          rready_m0,
	// M1, loads and stores
	output axi_addr_req_t ar_m1,
	input  logic          arready_m1,
	input  axi_r_rsp_t    r_m1,
	output logic          rready_m1,
	output axi_addr_req_t aw_m1,
	input  logic          awready_m1,
	output axi_w_req_t    w_m1,
	input  logic          wready_m1,
	input  logic          bvalid_m1,
	output logic          bready_m1
);

	logic fetch_start;
	logic fetch_done;
	logic data_start;
	logic data_done;
	logic is_store;

	assign is_store = (step.op == MEM_STORE);

	access_sequencer u_seq (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.op          (step.op),
		.fetch_start (fetch_start),
		.fetch_done  (fetch_done),
		.data_start  (data_start),
		.data_done   (data_done),
		.stall       (stall)
	);

	fetch_master u_fetch (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.start      (fetch_start),
		.fetch_addr (step.fetch_addr),
		.done       (fetch_done),
		.instr      (instr),
		.ar         (ar_m0),
		.arready    (arready_m0),
		.r          (r_m0),
		.rready     (rready_m0)
	);

	data_master u_data (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.start      (data_start),
		.is_store   (is_store),
		.data_addr  (step.data_addr),
		.store_data (step.store_data),
		.done       (data_done),
		.load_data  (load_data),
		.ar         (ar_m1),
		.arready    (arready_m1),
		.r          (r_m1),
		.rready     (rready_m1),
		.aw         (aw_m1),
		.awready    (awready_m1),
		.w          (w_m1),
		.wready     (wready_m1),
		.bvalid     (bvalid_m1),
		.bready     (bready_m1)
	);

endmodule

// File: src/data_master.sv
`timescale 1ns/100ps

module data_master
	import axi_bridge_pkg::*;
(
	input  logic          ACLK,
	input  logic          ARESETn,
	input  logic          start,
	input  logic          is_store,
	input  addr_t         data_addr,
	input  word_t         store_data,
	output logic          done,
	output word_t         load_data,
	output axi_addr_req_t ar,
	input  logic          arready,
	input  axi_r_rsp_t    r,
	output logic          rready,
	output axi_addr_req_t aw,
	input  logic          awready,
	output axi_w_req_t    w,
	input  logic          wready,
	input  logic          bvalid,
	output logic          bready
);

	rd_state_e rd_state;
	rd_state_e rd_state_nxt;
	wr_state_e wr_state;
	wr_state_e wr_state_nxt;
	addr_t     addr_q;
	word_t     wdata_q;
	logic      r_fire;
	logic      rd_end;
	logic      wr_end;

	assign r_fire = r.valid && rready;
	assign rd_end = (rd_state == RD_DATA) && r_fire && r.last;
	assign wr_end = (wr_state == WR_RESP) && bvalid;	// B handshake

	// ==================================================
	// Load FSM
	// ==================================================

	always_comb begin
		rd_state_nxt = rd_state;
		case (rd_state)
			RD_IDLE: if (start && !is_store) rd_state_nxt = RD_ADDR;
			RD_ADDR: if (arready) rd_state_nxt = RD_DATA;
			RD_DATA: if (rd_end) rd_state_nxt = RD_IDLE;
			default: rd_state_nxt = RD_IDLE;
		endcase
	end

	// ==================================================
	// Store FSM, AW then W then B
	// ==================================================

	always_comb begin
		wr_state_nxt = wr_state;
		case (wr_state)
			WR_IDLE: if (start && is_store) wr_state_nxt = WR_ADDR;
			WR_ADDR: if (awready) wr_state_nxt = WR_DATA;
			WR_DATA: if (wready) wr_state_nxt = WR_RESP;
			WR_RESP: if (bvalid) wr_state_nxt = WR_IDLE;
			default: wr_state_nxt = WR_IDLE;
		endcase
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			rd_state  <= RD_IDLE;
			wr_state  <= WR_IDLE;
			done      <= 1'b0;
			load_data <= '0;
		end else begin
			rd_state <= rd_state_nxt;
			wr_state <= wr_state_nxt;
			done     <= rd_end || wr_end;	// One cycle after last handshake
			if (r_fire) begin
				load_data <= r.data;
			end
		end
	end

	// Request payload, taken when the step starts
	always_ff @(posedge ACLK) begin
		if (start) begin
			addr_q  <= data_addr;
			wdata_q <= store_data;
		end
	end

	assign ar.valid = (rd_state == RD_ADDR);
	assign ar.addr  = addr_q;
	assign rready   = (rd_state == RD_DATA);

	assign aw.valid = (wr_state == WR_ADDR);
	assign aw.addr  = addr_q;
	assign w.valid  = (wr_state == WR_DATA);
	assign w.data   = wdata_q;
	assign w.last   = (wr_state == WR_DATA);	// Single beat
	assign bready   = (wr_state == WR_RESP);

	// ==================================================
	// Checks
	// ==================================================

	a_aw_hold: assert property (
		@(posedge ACLK) disable iff (!ARESETn)
		aw.valid && !awready |=> aw.valid && $stable(aw.addr)
	) else $error("M1 AW dropped or changed before awready");

	a_w_hold: assert property (
		@(posedge ACLK) disable iff (!ARESETn)
		w.valid && !wready |=> w.valid && $stable(w.data)
	) else $error("M1 W dropped or changed before wready");

	// One transaction at a time on M1
	a_one_path: assert property (
		@(posedge ACLK) disable iff (!ARESETn)
		!((rd_state != RD_IDLE) && (wr_state != WR_IDLE))
	) else $error("load and store FSMs active together");

endmodule

// File: src/fetch_master.sv
`timescale 1ns/100ps

module fetch_master
	import axi_bridge_pkg::*;
(
	input  logic          ACLK,
	input  logic          ARESETn,
	input  logic          start,
	input  addr_t         fetch_addr,
	output logic          done,
	output word_t         instr,
	output axi_addr_req_t ar,
	input  logic          arready,
	input  axi_r_rsp_t    r,
	output logic          rready
);

	rd_state_e state;
	rd_state_e state_nxt;
	addr_t     addr_q;	// Captured at start, held through AR
	logic      r_fire;

	assign r_fire = r.valid && rready;

	// ==================================================
	// Read FSM on M0
	// ==================================================

	always_comb begin
		state_nxt = state;
		case (state)
			RD_IDLE: if (start) state_nxt = RD_ADDR;
			RD_ADDR: if (arready) state_nxt = RD_DATA;	// AR handshake
			RD_DATA: if (r_fire && r.last) state_nxt = RD_IDLE;
			default: state_nxt = RD_IDLE;
		endcase
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state <= RD_IDLE;
			done  <= 1'b0;
			instr <= '0;
		end else begin
			state <= state_nxt;
			done  <= (state == RD_DATA) && r_fire && r.last;
			if (r_fire) begin
				instr <= r.data;	// Held until the next fetch
			end
		end
	end

	always_ff @(posedge ACLK) begin
		if (start && (state == RD_IDLE)) begin
			addr_q <= fetch_addr;
		end
	end

	assign ar.valid = (state == RD_ADDR);
	assign ar.addr  = addr_q;
	assign rready   = (state == RD_DATA);

	// ==================================================
	// Checks
	// ==================================================

	a_ar_hold: assert property (
		@(posedge ACLK) disable iff (!ARESETn)
		ar.valid && !arready |=> ar.valid && $stable(ar.addr)
	) else $error("M0 AR dropped or changed before arready");

endmodule

// File: verification/bridge_checker.sv
`timescale 1ns/100ps

module bridge_checker
	import axi_bridge_pkg::*;
(
	input  logic          ACLK,
	input  logic          ARESETn,
	input  cpu_step_t     step,
	input  logic          stall,
	input  word_t         instr,
	input  word_t         load_data,
	input  axi_addr_req_t ar_m0,
	input  logic          arready_m0,
	input  logic          rready_m0,
	input  axi_addr_req_t ar_m1,
	input  logic          arready_m1,
	input  axi_r_rsp_t    r_m1,
	input  logic          rready_m1,
	input  axi_addr_req_t aw_m1,
	input  logic          awready_m1,
	input  axi_w_req_t    w_m1,
	input  logic          wready_m1,
	input  logic          bvalid_m1,
	input  logic          bready_m1,
	output int            passed,
	output int            failed,
	output int            errors
);

	word_t         shadow [addr_t];	// Words stored through M1
	word_t         exp_load;
	logic          data_seen;	// Final M1 handshake of this step
	int            step_idx;
	int            err_mark;
	axi_addr_req_t ar0_q;
	axi_addr_req_t ar1_q;
	axi_addr_req_t aw_q;
	axi_w_req_t    w_q;
	logic [3:0]    rdy_q;	// Readies of the previous cycle

	function automatic word_t rule_value(input addr_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a ^ 32'hA5A5A5A5;
	endfunction

	task automatic check_value(input string name, input word_t exp, input word_t got);
		if (got !== exp) begin
			$display("CHECK FAILED %s expected 0x%h, got 0x%h", name, exp, got);
			errors++;
		end
	endtask

	// A pending valid must come back unchanged
	task automatic check_hold(input string name, input logic pend,
		input logic [33:0] prev, input logic [33:0] cur);
		if (pend && (cur !== prev)) begin
			$display("CHECK FAILED %s held 0x%h, now 0x%h", name, prev, cur);
			errors++;
		end
	endtask

	// ==================================================
	// Reset values
	// ==================================================

	initial begin
		passed    = 0;
		failed    = 0;
		errors    = 0;
		step_idx  = 0;
		exp_load  = '0;
		data_seen = 1'b0;
		@(posedge ARESETn);
		if ({stall, ar_m0.valid, rready_m0, ar_m1.valid, rready_m1,
			aw_m1.valid, w_m1.valid, bready_m1} !== 8'h80) begin
			$display("CHECK FAILED reset outputs expected 0x80, got 0x%h", {stall,
				ar_m0.valid, rready_m0, ar_m1.valid, rready_m1, aw_m1.valid,
				w_m1.valid, bready_m1});
			errors++;
			failed++;
			$display("Reset: FAILED");
		end else begin
			passed++;
			$display("Reset: ok");
		end
		err_mark = errors;
	end

	// ==================================================
	// Per cycle checks
	// ==================================================

	always @(posedge ACLK) begin
		if (ARESETn) begin
			check_hold("ar_m0", ar0_q.valid && !rdy_q[3], ar0_q, ar_m0);
			check_hold("ar_m1", ar1_q.valid && !rdy_q[2], ar1_q, ar_m1);
			check_hold("aw_m1", aw_q.valid && !rdy_q[1], aw_q, aw_m1);
			check_hold("w_m1", w_q.valid && !rdy_q[0], w_q, w_m1);
			if (ar_m0.valid && arready_m0) begin
				check_value("ar_m0.addr", step.fetch_addr, ar_m0.addr);
			end
			if (ar_m1.valid && arready_m1) begin
				check_value("ar_m1.addr", step.data_addr, ar_m1.addr);
			end
			if (aw_m1.valid && awready_m1) begin
				check_value("aw_m1.addr", step.data_addr, aw_m1.addr);
			end
			if (w_m1.valid && wready_m1) begin
				check_value("w_m1.data", step.store_data, w_m1.data);
				check_value("w_m1.last", 32'h1, w_m1.last);	// Single beat
				shadow[step.data_addr] = step.store_data;
			end
			if ((r_m1.valid && rready_m1) || (bvalid_m1 && bready_m1)) begin
				data_seen = 1'b1;
			end
			// Fetch must wait for the data access
			if (ar_m0.valid && !ar0_q.valid && (step.op != MEM_NONE) && !data_seen) begin
				$display("Step %0d: M0 fetch began before the data access ended", step_idx);
				errors++;
			end
			if (!stall) begin	// Release cycle of a step
				if (step.op == MEM_LOAD) begin
					exp_load = rule_value(step.data_addr);
				end
				check_value("instr", rule_value(step.fetch_addr), instr);
				check_value("load_data", exp_load, load_data);
				if (errors == err_mark) begin
					passed++;
					$display("Step %0d fetch 0x%h op %0d: ok", step_idx, step.fetch_addr, step.op);
				end else begin
					failed++;
					$display("Step %0d fetch 0x%h op %0d: FAILED", step_idx, step.fetch_addr,
						step.op);
				end
				err_mark  = errors;
				data_seen = 1'b0;
				step_idx++;
			end
		end
		ar0_q = ar_m0;
		ar1_q = ar_m1;
		aw_q  = aw_m1;
		w_q   = w_m1;
		rdy_q = {arready_m0, arready_m1, awready_m1, wready_m1};
	end

endmodule

// File: verification/tb_cpu_axi_bridge.sv
`timescale 1ns/100ps
`include "axi_bridge_macros.svh"

module tb_cpu_axi_bridge
	import axi_bridge_pkg::*;
();

	localparam int NUM_STEPS    = 10;
	localparam int RESET_CYCLES = 2;
	localparam int CYCLE_LIMIT  = NUM_STEPS * `TB_STEP_SLACK + RESET_CYCLES;
	localparam int DRIVE_DLY    = 2;	// ns after the rising edge

	logic          ACLK;
	logic          ARESETn;
	cpu_step_t     step;
	logic          stall;
	word_t         instr;
	word_t         load_data;
	axi_addr_req_t ar_m0;
	logic          arready_m0;
	axi_r_rsp_t    r_m0;
	logic          rready_m0;
	axi_addr_req_t ar_m1;
	logic          arready_m1;
	axi_r_rsp_t    r_m1;
	logic          rready_m1;
	axi_addr_req_t aw_m1;
	logic          awready_m1;
	axi_w_req_t    w_m1;
	logic          wready_m1;
	logic          bvalid_m1;
	logic          bready_m1;
	int            passed;
	int            failed;
	int            errors;
	int            cycles;
	cpu_step_t     steps [NUM_STEPS];
	word_t         mem [addr_t];	// Slave memory, written words only

	initial begin
		ACLK = 1'b0;
		forever #20 ACLK = ~ACLK;
	end

	cpu_axi_bridge dut0 (.*);

	bridge_checker chk0 (.*);

	// ==================================================
	// AXI slave model
	// ==================================================

	function automatic word_t mem_value(input addr_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return a ^ 32'hA5A5A5A5;	// Unwritten fill
	endfunction

	function automatic logic ar_valid(input int m);
		return (m == 0) ? ar_m0.valid : ar_m1.valid;
	endfunction

	function automatic addr_t ar_addr(input int m);
		return (m == 0) ? ar_m0.addr : ar_m1.addr;
	endfunction

	function automatic logic rready_of(input int m);
		return (m == 0) ? rready_m0 : rready_m1;
	endfunction

	task automatic set_arready(input int m, input logic v);
		if (m == 0) arready_m0 = v;
		else arready_m1 = v;
	endtask

	task automatic set_r(input int m, input axi_r_rsp_t v);
		if (m == 0) r_m0 = v;
		else r_m1 = v;
	endtask

	// Read slave for M0 (m = 0) or M1 (m = 1)
	task automatic serve_read(input int m);
		addr_t a;
		forever begin
			@(posedge ACLK);
			while (!ar_valid(m)) @(posedge ACLK);
			repeat ($urandom_range(3)) @(posedge ACLK);
			#DRIVE_DLY set_arready(m, 1'b1);
			@(posedge ACLK);	// AR handshake
			a = ar_addr(m);
			#DRIVE_DLY set_arready(m, 1'b0);
			repeat ($urandom_range(3)) @(posedge ACLK);
			#DRIVE_DLY set_r(m, '{1'b1, mem_value(a), 1'b1});
			@(posedge ACLK);
			while (!rready_of(m)) @(posedge ACLK);
			#DRIVE_DLY set_r(m, '0);
		end
	endtask

	task automatic serve_write();
		addr_t a;
		forever begin
			@(posedge ACLK);
			while (!aw_m1.valid) @(posedge ACLK);
			repeat ($urandom_range(3)) @(posedge ACLK);
			#DRIVE_DLY awready_m1 = 1'b1;
			@(posedge ACLK);
			a = aw_m1.addr;
			#DRIVE_DLY awready_m1 = 1'b0;
			repeat ($urandom_range(3)) @(posedge ACLK);
			#DRIVE_DLY wready_m1 = 1'b1;
			@(posedge ACLK);
			while (!w_m1.valid) @(posedge ACLK);
			mem[a] = w_m1.data;	// W handshake
			#DRIVE_DLY wready_m1 = 1'b0;
			repeat ($urandom_range(3)) @(posedge ACLK);
			#DRIVE_DLY bvalid_m1 = 1'b1;
			@(posedge ACLK);
			while (!bready_m1) @(posedge ACLK);
			#DRIVE_DLY bvalid_m1 = 1'b0;
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	task automatic load_table();
		// Fetch address, operation, data address, store data
		steps[0] = '{32'h0000_0100, MEM_NONE,  32'h0000_0000, 32'h0000_0000};
		steps[1] = '{32'h0000_0104, MEM_LOAD,  32'h0000_2000, 32'h0000_0000};
		steps[2] = '{32'h0000_0108, MEM_STORE, 32'h0000_2004, 32'hDEAD_BEEF};
		steps[3] = '{32'h0000_010C, MEM_NONE,  32'h0000_0000, 32'h0000_0000};
		steps[4] = '{32'h0000_0110, MEM_LOAD,  32'h0000_2004, 32'h0000_0000};
		steps[5] = '{32'h0000_0114, MEM_STORE, 32'h0000_3000, 32'h1234_5678};
		steps[6] = '{32'h0000_0118, MEM_NONE,  32'h0000_0000, 32'h0000_0000};
		steps[7] = '{32'h0000_011C, MEM_LOAD,  32'h0000_3000, 32'h0000_0000};
		steps[8] = '{32'h0000_0120, MEM_STORE, 32'h0000_0124, 32'h0BAD_F00D};
		steps[9] = '{32'h0000_0124, MEM_NONE,  32'h0000_0000, 32'h0000_0000};	// Fetch stored word
	endtask

	initial begin
		void'($urandom(5));
		load_table();
		ARESETn    = 1'b0;
		step       = steps[0];	// First step is taken right after reset
		arready_m0 = 1'b0;
		arready_m1 = 1'b0;
		r_m0       = '0;
		r_m1       = '0;
		awready_m1 = 1'b0;
		wready_m1  = 1'b0;
		bvalid_m1  = 1'b0;
		fork
			serve_read(0);
			serve_read(1);
			serve_write();
		join_none
		repeat (RESET_CYCLES) @(posedge ACLK);
		#DRIVE_DLY ARESETn = 1'b1;
		for (int i = 0; i < NUM_STEPS; i++) begin
			if (i > 0) begin
				@(posedge ACLK);	// Edge after the release cycle
				#DRIVE_DLY step = steps[i];
			end
			@(negedge ACLK);
			while (stall) @(negedge ACLK);
		end
		@(posedge ACLK);
		#DRIVE_DLY;
		$display("Tests passed: %0d, failed: %0d, check errors: %0d", passed, failed, errors);
		if ((failed == 0) && (errors == 0) && (passed == NUM_STEPS + 1)) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Run limit
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge ACLK);
			cycles++;
		end
		$display("Timeout: the steps did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

endmodule
